// File: Bender.yml
package:
  name: os_generator

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - os_gen_pkg.sv
      - os_request_capture.sv
      - os_sequencer.sv
      - pipe_lane_packer.sv
      - os_generator_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - os_generator_properties.sv
      - tb_os_generator.sv

// File: compile.f
+incdir+.
os_gen_pkg.sv
os_request_capture.sv
os_sequencer.sv
pipe_lane_packer.sv
os_generator_top.sv
os_generator_properties.sv
tb_os_generator.sv

// File: os_gen_defines.svh
`ifndef OS_GEN_DEFINES_SVH
`define OS_GEN_DEFINES_SVH

// lane count used by the top level when not overridden
`define OS_LANES     4

// special symbols (K codes)
`define SYM_COM      8'hBC
`define SYM_PAD      8'hF7
`define SYM_SKP      8'h1C
`define SYM_EIDL     8'h7C

// training set identifier fill bytes (D codes)
`define TS1_ID       8'h4A
`define TS2_ID       8'h45

// beats per ordered set at two symbols per beat
`define TS_BEATS     8       // 16 symbols
`define SHORT_BEATS  2       // 4 symbols

// fixed training set bytes
`define TS_NFTS      8'h00   // symbol 3
`define RATE_GEN1    8'h02
`define RATE_GEN2    8'h04
`define RATE_GEN3    8'h08
`define RATE_GEN4    8'h10
`define RATE_GEN5    8'h20
`define CTRL_LOOPBK  8'h04   // training control with loopback bit
`define CTRL_NONE    8'h00

`endif

// File: os_gen_pkg.sv
package os_gen_pkg;

   // ordered-set opcode
   typedef enum logic [1:0] {
      OS_TS1  = 2'd0,
      OS_TS2  = 2'd1,
      OS_SKP  = 2'd2,
      OS_EIOS = 2'd3
   } os_type_e;

   // how symbol 2 of a training set carries the lane number
   typedef enum logic [1:0] {
      LANE_PAD     = 2'd0,   // PAD on every lane
      LANE_ASCEND  = 2'd1,   // lane i carries i
      LANE_DESCEND = 2'd2    // lane i carries lanes-1-i
   } lane_mode_e;

   // sequencer FSM
   typedef enum logic {
      SEQ_IDLE = 1'b0,
      SEQ_SEND = 1'b1
   } seq_state_e;

   function automatic logic is_training_set(input os_type_e t);
      return (t == OS_TS1) || (t == OS_TS2);
   endfunction

endpackage

// File: os_generator_properties.sv
`timescale 1ns/1ns
`include "os_gen_defines.svh"

module os_generator_properties #(
   parameter int lanes = `OS_LANES
) (
   input logic                 pclk,
   input logic                 reset_n,
   input logic                 out_valid,
   input logic                 out_ready,
   input logic [lanes*16-1:0]  out_data,
   input logic [lanes*2-1:0]   out_datak,
   input logic                 out_last
);

   int fail_count = 0;   // failed assertions so far

   // a stalled beat keeps its valid and payload
   property hold_until_ready;
      @(posedge pclk) disable iff (!reset_n)
         out_valid && !out_ready |=> out_valid && $stable(out_data)
                                     && $stable(out_datak) && $stable(out_last);
   endproperty

   property idle_in_reset;
      @(posedge pclk) !reset_n |=> !out_valid;
   endproperty

   property last_needs_valid;
      @(posedge pclk) disable iff (!reset_n)
         out_last |-> out_valid;
   endproperty

   assert property (hold_until_ready)
      else begin
         $error("output beat changed or dropped while out_ready was low");
         fail_count++;
      end
   assert property (idle_in_reset)
      else begin
         $error("out_valid high during reset");
         fail_count++;
      end
   assert property (last_needs_valid)
      else begin
         $error("out_last high without out_valid");
         fail_count++;
      end

endmodule

bind os_generator_top os_generator_properties #(.lanes(lanes)) u_properties (
   .pclk(pclk), .reset_n(reset_n), .out_valid(out_valid), .out_ready(out_ready),
   .out_data(out_data), .out_datak(out_datak), .out_last(out_last)
);

// File: os_generator_top.sv
`timescale 1ns/1ns
`include "os_gen_defines.svh"

module os_generator_top import os_gen_pkg::*; #(
   parameter int lanes = `OS_LANES
) (
   input  logic                 pclk,
   input  logic                 reset_n,
   input  logic                 req_valid,
   output logic                 req_ready,
   input  os_type_e             os_type,
   input  logic [7:0]           link_number,
   input  logic [2:0]           rate,
   input  logic                 loopback,
   input  lane_mode_e           lane_mode,
   output logic                 out_valid,
   input  logic                 out_ready,
   output logic [lanes*16-1:0]  out_data,
   output logic [lanes*2-1:0]   out_datak,
   output logic                 out_last
);

   // capture to sequencer
   logic        hdr_valid;
   logic        hdr_ready;
   os_type_e    hdr_type;
   logic [7:0]  hdr_link_sym;
   logic        hdr_link_k;
   logic [7:0]  hdr_rate_sym;
   logic [7:0]  hdr_ctrl_sym;
   lane_mode_e  hdr_lane_mode;

   // sequencer to packer
   logic        beat_valid;
   logic        beat_ready;
   logic [7:0]  sym_lo;
   logic [7:0]  sym_hi;
   logic        k_lo;
   logic        k_hi;
   logic        beat_lane_field;
   lane_mode_e  beat_lane_mode;
   logic        beat_last;

   os_request_capture u_capture (
      .pclk, .reset_n, .req_valid, .req_ready, .os_type, .link_number, .rate,
      .loopback, .lane_mode, .hdr_valid, .hdr_ready, .hdr_type, .hdr_link_sym,
      .hdr_link_k, .hdr_rate_sym, .hdr_ctrl_sym, .hdr_lane_mode
   );

   os_sequencer u_sequencer (
      .pclk, .reset_n, .hdr_valid, .hdr_ready, .hdr_type, .hdr_link_sym,
      .hdr_link_k, .hdr_rate_sym, .hdr_ctrl_sym, .hdr_lane_mode, .beat_valid,
      .beat_ready, .sym_lo, .sym_hi, .k_lo, .k_hi, .beat_lane_field,
      .beat_lane_mode, .beat_last
   );

   pipe_lane_packer #(.lanes(lanes)) u_packer (
      .pclk, .reset_n, .beat_valid, .beat_ready, .sym_lo, .sym_hi, .k_lo, .k_hi,
      .beat_lane_field, .beat_lane_mode, .beat_last, .out_valid, .out_ready,
      .out_data, .out_datak, .out_last
   );

endmodule

// File: os_request_capture.sv
`timescale 1ns/1ns
`include "os_gen_defines.svh"

module os_request_capture import os_gen_pkg::*; (
   input  logic        pclk,
   input  logic        reset_n,
   input  logic        req_valid,
   output logic        req_ready,
   input  os_type_e    os_type,
   input  logic [7:0]  link_number,
   input  logic [2:0]  rate,
   input  logic        loopback,
   input  lane_mode_e  lane_mode,
   output logic        hdr_valid,
   input  logic        hdr_ready,
   output os_type_e    hdr_type,
   output logic [7:0]  hdr_link_sym,
   output logic        hdr_link_k,
   output logic [7:0]  hdr_rate_sym,
   output logic [7:0]  hdr_ctrl_sym,
   output lane_mode_e  hdr_lane_mode
);

   logic req_fire;
   logic hdr_fire;

   // one-hot data rate byte of the training set
   function automatic logic [7:0] rate_byte(input logic [2:0] code);
      case (code)
         3'd1:    rate_byte = `RATE_GEN1;
         3'd2:    rate_byte = `RATE_GEN2;
         3'd3:    rate_byte = `RATE_GEN3;
         3'd4:    rate_byte = `RATE_GEN4;
         default: rate_byte = `RATE_GEN5;
      endcase
   endfunction

   assign req_ready = !hdr_valid;   // single entry, free when empty
   assign req_fire  = req_valid && req_ready;
   assign hdr_fire  = hdr_valid && hdr_ready;

   always_ff @(posedge pclk) begin
      if (!reset_n) begin
         hdr_valid <= 1'b0;
      end else if (req_fire) begin
         hdr_valid <= 1'b1;
      end else if (hdr_fire) begin
         hdr_valid <= 1'b0;
      end
   end

   // header bytes are encoded once, at acceptance
   always_ff @(posedge pclk) begin
      if (req_fire) begin
         hdr_type      <= os_type;
         hdr_lane_mode <= lane_mode;
         hdr_rate_sym  <= rate_byte(rate);
         hdr_ctrl_sym  <= loopback ? `CTRL_LOOPBK : `CTRL_NONE;
         if (link_number == 8'h00) begin   // unassigned link goes out as PAD
            hdr_link_sym <= `SYM_PAD;
            hdr_link_k   <= 1'b1;
         end else begin
            hdr_link_sym <= link_number;
            hdr_link_k   <= 1'b0;
         end
      end
   end

endmodule

// File: os_sequencer.sv
`timescale 1ns/1ns
`include "os_gen_defines.svh"

module os_sequencer import os_gen_pkg::*; (
   input  logic        pclk,
   input  logic        reset_n,
   input  logic        hdr_valid,
   output logic        hdr_ready,
   input  os_type_e    hdr_type,
   input  logic [7:0]  hdr_link_sym,
   input  logic        hdr_link_k,
   input  logic [7:0]  hdr_rate_sym,
   input  logic [7:0]  hdr_ctrl_sym,
   input  lane_mode_e  hdr_lane_mode,
   output logic        beat_valid,
   input  logic        beat_ready,
   output logic [7:0]  sym_lo,
   output logic [7:0]  sym_hi,
   output logic        k_lo,
   output logic        k_hi,
   output logic        beat_lane_field,
   output lane_mode_e  beat_lane_mode,
   output logic        beat_last
);

   localparam int idx_w = $clog2(`TS_BEATS);

   seq_state_e        state;
   logic [idx_w-1:0]  beat_idx;   // symbol pair index within the set
   os_type_e          cur_type;
   logic [7:0]        cur_link_sym;
   logic              cur_link_k;
   logic [7:0]        cur_rate_sym;
   logic [7:0]        cur_ctrl_sym;
   lane_mode_e        hdr_lane_mode_q;
   logic              is_ts;
   logic              hdr_take;
   logic              beat_fire;
   logic [7:0]        ts_fill;
   logic [7:0]        short_fill;

   assign is_ts      = is_training_set(cur_type);
   assign ts_fill    = (cur_type == OS_TS2) ? `TS2_ID : `TS1_ID;
   assign short_fill = (cur_type == OS_SKP) ? `SYM_SKP : `SYM_EIDL;

   assign beat_valid = (state == SEQ_SEND);
   assign beat_fire  = beat_valid && beat_ready;
   assign beat_last  = is_ts ? (beat_idx == idx_w'(`TS_BEATS - 1))
                             : (beat_idx == idx_w'(`SHORT_BEATS - 1));

   // next header is taken on the last beat so sets run back to back
   assign hdr_ready  = (state == SEQ_IDLE) || (beat_fire && beat_last);
   assign hdr_take   = hdr_valid && hdr_ready;

   assign beat_lane_field = is_ts && (beat_idx == idx_w'(1));
   assign beat_lane_mode  = hdr_lane_mode_q;

   always_ff @(posedge pclk) begin
      if (!reset_n) begin
         state    <= SEQ_IDLE;
         beat_idx <= '0;
      end else if (hdr_take) begin
         state    <= SEQ_SEND;
         beat_idx <= '0;
      end else if (beat_fire) begin
         if (beat_last) begin
            state    <= SEQ_IDLE;
            beat_idx <= '0;
         end else begin
            beat_idx <= beat_idx + 1'b1;
         end
      end
   end

   always_ff @(posedge pclk) begin
      if (hdr_take) begin
         cur_type        <= hdr_type;
         cur_link_sym    <= hdr_link_sym;
         cur_link_k      <= hdr_link_k;
         cur_rate_sym    <= hdr_rate_sym;
         cur_ctrl_sym    <= hdr_ctrl_sym;
         hdr_lane_mode_q <= hdr_lane_mode;
      end
   end

   // symbol pair for the current beat
   always_comb begin
      if (is_ts) begin
         case (beat_idx)
            0: begin
               {sym_lo, k_lo} = {`SYM_COM, 1'b1};
               {sym_hi, k_hi} = {cur_link_sym, cur_link_k};
            end
            1: begin
               {sym_lo, k_lo} = {`SYM_PAD, 1'b1};   // lane number, filled in by the packer
               {sym_hi, k_hi} = {`TS_NFTS, 1'b0};
            end
            2: begin
               {sym_lo, k_lo} = {cur_rate_sym, 1'b0};
               {sym_hi, k_hi} = {cur_ctrl_sym, 1'b0};
            end
            default: begin
               {sym_lo, k_lo} = {ts_fill, 1'b0};
               {sym_hi, k_hi} = {ts_fill, 1'b0};
            end
         endcase
      end else begin
         sym_lo = (beat_idx == '0) ? `SYM_COM : short_fill;
         sym_hi = short_fill;
         k_lo   = 1'b1;   // SKP and EIOS are all K
         k_hi   = 1'b1;
      end
   end

endmodule

// File: pipe_lane_packer.sv
`timescale 1ns/1ns
`include "os_gen_defines.svh"

module pipe_lane_packer import os_gen_pkg::*; #(
   parameter int lanes = `OS_LANES
) (
   input  logic                 pclk,
   input  logic                 reset_n,
   input  logic                 beat_valid,
   output logic                 beat_ready,
   input  logic [7:0]           sym_lo,
   input  logic [7:0]           sym_hi,
   input  logic                 k_lo,
   input  logic                 k_hi,
   input  logic                 beat_lane_field,
   input  lane_mode_e           beat_lane_mode,
   input  logic                 beat_last,
   output logic                 out_valid,
   input  logic                 out_ready,
   output logic [lanes*16-1:0]  out_data,
   output logic [lanes*2-1:0]   out_datak,
   output logic                 out_last
);

   logic [lanes*8-1:0]  lo_bytes;   // earlier symbol, lane i in byte i
   logic [lanes*8-1:0]  hi_bytes;   // later symbol
   logic [lanes-1:0]    lo_k;
   logic [lanes-1:0]    hi_k;
   logic                load;

   assign beat_ready = out_ready || !out_valid;
   assign load       = beat_valid && beat_ready;

   // replicate both symbols across the lanes
   always_comb begin
      for (int i = 0; i < lanes; i++) begin
         hi_bytes[8*i +: 8] = sym_hi;
         hi_k[i]            = k_hi;
         if (beat_lane_field) begin
            case (beat_lane_mode)
               LANE_ASCEND: begin
                  lo_bytes[8*i +: 8] = 8'(i);
                  lo_k[i]            = 1'b0;
               end
               LANE_DESCEND: begin
                  lo_bytes[8*i +: 8] = 8'(lanes - 1 - i);
                  lo_k[i]            = 1'b0;
               end
               default: begin
                  lo_bytes[8*i +: 8] = `SYM_PAD;
                  lo_k[i]            = 1'b1;
               end
            endcase
         end else begin
            lo_bytes[8*i +: 8] = sym_lo;
            lo_k[i]            = k_lo;
         end
      end
   end

   always_ff @(posedge pclk) begin
      if (!reset_n) begin
         out_valid <= 1'b0;
         out_last  <= 1'b0;
      end else if (beat_ready) begin
         out_valid <= beat_valid;
         out_last  <= beat_valid && beat_last;
      end
   end

   always_ff @(posedge pclk) begin
      if (load) begin
         out_data  <= {hi_bytes, lo_bytes};
         out_datak <= {hi_k, lo_k};
      end
   end

endmodule

// File: tb_os_generator.sv
`timescale 1ns/1ns
`include "os_gen_defines.svh"

module tb_os_generator import os_gen_pkg::*; ();

   localparam int lanes          = 4;
   localparam int num_rows       = 10;
   localparam int timeout_cycles = num_rows * `TS_BEATS * 4 + 200;

   // row: type[35:34] link[33:26] rate[25:23] loopback[22] mode[21:20]
   //      expected rate byte[19:12] expected control byte[11:4] beats[3:0]
   localparam logic [35:0] stim [0:num_rows-1] = '{
      {OS_TS1,  8'h05, 3'd1, 1'b0, LANE_ASCEND,  8'h02, 8'h00, 4'd8},
      {OS_TS2,  8'h05, 3'd2, 1'b1, LANE_DESCEND, 8'h04, 8'h04, 4'd8},
      {OS_TS1,  8'h22, 3'd3, 1'b0, LANE_PAD,     8'h08, 8'h00, 4'd8},
      {OS_TS2,  8'h81, 3'd4, 1'b0, LANE_ASCEND,  8'h10, 8'h00, 4'd8},
      {OS_TS1,  8'h00, 3'd5, 1'b1, LANE_PAD,     8'h20, 8'h04, 4'd8},
      {OS_TS2,  8'h00, 3'd0, 1'b0, LANE_PAD,     8'h20, 8'h00, 4'd8},
      {OS_SKP,  8'h00, 3'd0, 1'b0, LANE_PAD,     8'h00, 8'h00, 4'd2},
      {OS_EIOS, 8'h00, 3'd0, 1'b0, LANE_PAD,     8'h00, 8'h00, 4'd2},
      {OS_TS1,  8'h0F, 3'd7, 1'b0, LANE_DESCEND, 8'h20, 8'h00, 4'd8},
      {OS_SKP,  8'h10, 3'd1, 1'b1, LANE_ASCEND,  8'h00, 8'h00, 4'd2}
   };

   logic                  pclk;
   logic                  reset_n;
   logic                  req_valid;
   logic                  req_ready;
   os_type_e              os_type;
   logic [7:0]            link_number;
   logic [2:0]            rate;
   logic                  loopback;
   lane_mode_e            lane_mode;
   logic                  out_valid;
   logic                  out_ready;
   logic [lanes*16-1:0]   out_data;
   logic [lanes*2-1:0]    out_datak;
   logic                  out_last;

   int  cycle = 0;
   int  errors = 0;
   int  sets_sent = 0;
   int  sets_done = 0;
   int  latency_checks = 0;
   int  drive_row = 0;        // row currently offered on the request port
   int  beat_idx = 0;
   int  accept_cycle = 0;
   bit  rise_pending = 0;     // first beat after an idle output still expected
   bit  prev_valid = 0;
   bit  stall_en = 0;
   int  pend_rows [$];        // accepted rows in request order

   os_generator_top #(.lanes(lanes)) dut (
      .pclk, .reset_n, .req_valid, .req_ready, .os_type, .link_number, .rate,
      .loopback, .lane_mode, .out_valid, .out_ready, .out_data, .out_datak,
      .out_last
   );

   initial pclk = 1'b0;
   always #50 pclk = ~pclk;

   always @(posedge pclk) cycle <= cycle + 1;

   // symbol s of the ordered set in row r as seen on one lane, {k, byte}
   function automatic logic [8:0] ref_symbol(input int r, input int lane, input int s);
      logic [1:0] t;
      logic [7:0] link;
      logic [1:0] mode;
      logic [7:0] id;
      t    = stim[r][35:34];
      link = stim[r][33:26];
      mode = stim[r][21:20];
      id   = (t == OS_TS2) ? `TS2_ID : `TS1_ID;
      if (t == OS_SKP || t == OS_EIOS) begin
         if (s == 0)
            return {1'b1, `SYM_COM};
         return {1'b1, (t == OS_SKP) ? `SYM_SKP : `SYM_EIDL};
      end
      case (s)
         0: return {1'b1, `SYM_COM};
         1: return (link == 8'h00) ? {1'b1, `SYM_PAD} : {1'b0, link};
         2: begin
            if (mode == LANE_ASCEND)
               return {1'b0, 8'(lane)};
            if (mode == LANE_DESCEND)
               return {1'b0, 8'(lanes - 1 - lane)};
            return {1'b1, `SYM_PAD};
         end
         3: return 9'h000;
         4: return {1'b0, stim[r][19:12]};   // one-hot rate byte
         5: return {1'b0, stim[r][11:4]};    // training control
         default: return {1'b0, id};
      endcase
   endfunction

   task automatic expected_beat(input int r, input int beat,
                                output logic [lanes*16-1:0] d,
                                output logic [lanes*2-1:0] k);
      logic [8:0] lo;
      logic [8:0] hi;
      for (int i = 0; i < lanes; i++) begin
         lo = ref_symbol(r, i, 2 * beat);
         hi = ref_symbol(r, i, 2 * beat + 1);
         d[8*i +: 8]             = lo[7:0];
         d[lanes*8 + 8*i +: 8]   = hi[7:0];
         k[i]                    = lo[8];
         k[lanes + i]            = hi[8];
      end
   endtask

   task automatic send_request(input int r);
      logic accepted;
      drive_row   = r;
      req_valid   = 1'b1;
      os_type     = os_type_e'(stim[r][35:34]);
      link_number = stim[r][33:26];
      rate        = stim[r][25:23];
      loopback    = stim[r][22];
      lane_mode   = lane_mode_e'(stim[r][21:20]);
      accepted    = 1'b0;
      while (!accepted) begin
         @(posedge pclk);
         accepted = req_ready;
         #1;
      end
      req_valid = 1'b0;
      sets_sent++;
   endtask

   task automatic wait_sets_done();
      while (sets_done < sets_sent) begin
         @(posedge pclk);
         #1;
      end
   endtask

   // random back-pressure, 1 in 4 cycles stalled
   always @(posedge pclk) begin
      #1;
      if (stall_en)
         out_ready = ($urandom % 4) != 0;
      else
         out_ready = 1'b1;
   end

   // output checker and request bookkeeping
   always @(posedge pclk) begin
      logic [lanes*16-1:0] exp_d;
      logic [lanes*2-1:0]  exp_k;
      logic                exp_last;
      logic                was_idle;
      int                  r;
      if (reset_n) begin
         was_idle = (pend_rows.size() == 0) && !out_valid;
         if (rise_pending && out_valid && !prev_valid) begin
            // out_valid went high at the previous edge
            if (cycle - 1 - accept_cycle != 2) begin
               $display("first beat rose %0d cycles after acceptance instead of 2",
                        cycle - 1 - accept_cycle);
               errors++;
            end
            rise_pending = 0;
            latency_checks++;
         end
         if (out_valid && out_ready) begin
            if (pend_rows.size() == 0) begin
               $display("beat received with no request outstanding");
               errors++;
            end else begin
               r = pend_rows[0];
               expected_beat(r, beat_idx, exp_d, exp_k);
               exp_last = (beat_idx == int'(stim[r][3:0]) - 1);
               if (out_data !== exp_d) begin
                  $display("MISMATCH out_data row %0d beat %0d: got %h expected %h",
                           r, beat_idx, out_data, exp_d);
                  errors++;
               end
               if (out_datak !== exp_k) begin
                  $display("MISMATCH out_datak row %0d beat %0d: got %h expected %h",
                           r, beat_idx, out_datak, exp_k);
                  errors++;
               end
               if (out_last !== exp_last) begin
                  $display("MISMATCH out_last row %0d beat %0d: got %h expected %h",
                           r, beat_idx, out_last, exp_last);
                  errors++;
               end
               if (exp_last) begin
                  void'(pend_rows.pop_front());
                  beat_idx = 0;
                  sets_done++;
               end else begin
                  beat_idx++;
               end
            end
         end
         if (req_valid && req_ready) begin
            pend_rows.push_back(drive_row);
            if (was_idle) begin
               rise_pending = 1;
               accept_cycle = cycle;
            end
         end
         prev_valid = out_valid;
      end
   end

   initial begin
      while (cycle < timeout_cycles)
         @(posedge pclk);
      $display("timeout after %0d cycles, %0d of %0d ordered sets received",
               cycle, sets_done, sets_sent);
      $display("** FAIL **");
      $finish;
   end

   initial begin
      void'($urandom(32'h353c));
      reset_n     = 1'b0;
      req_valid   = 1'b0;
      os_type     = OS_TS1;
      link_number = 8'h00;
      rate        = 3'd0;
      loopback    = 1'b0;
      lane_mode   = LANE_PAD;
      out_ready   = 1'b1;
      repeat (16) @(posedge pclk);
      #1 reset_n = 1'b1;
      @(posedge pclk);
      #1;
      if (req_ready !== 1'b1) begin
         $display("MISMATCH req_ready after reset: got %h expected 1", req_ready);
         errors++;
      end
      if (out_valid !== 1'b0) begin
         $display("MISMATCH out_valid after reset: got %h expected 0", out_valid);
         errors++;
      end
      for (int r = 0; r < num_rows; r++) begin   // one set at a time, no stalls
         send_request(r);
         wait_sets_done();
      end
      stall_en = 1;
      for (int r = 0; r < num_rows; r++)         // back to back under stalls
         send_request(r);
      wait_sets_done();
      stall_en = 0;
      if (latency_checks < num_rows) begin
         $display("first-beat latency was checked only %0d times", latency_checks);
         errors++;
      end
      errors += dut.u_properties.fail_count;
      $display("errors: %0d (assertions %0d), ordered sets checked: %0d of %0d",
               errors, dut.u_properties.fail_count, sets_done, sets_sent);
      if (errors == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule
